//--- fog_macros.svh
`ifndef FOG_MACROS_SVH
`define FOG_MACROS_SVH

// Raw ADC sample width
`define FOG_ADC_W 14

// Datapath word for errors, steps, ramp and config words
`define FOG_DATA_W 32

// DAC bus width
`define FOG_DAC_W 16

// FIR length, N8FC2 set
`define FOG_FIR_TAPS 8

// Coefficients sum to about 2^15
// so this shift brings the FIR output back to unity DC gain
`define FOG_FIR_SHIFT 15

`endif

//--- fog_cfg_pkg.sv
`include "fog_macros.svh"

package fog_cfg_pkg;

	// Unsigned config word, counts and DAC levels
	typedef logic [`FOG_DATA_W-1:0] cfg_word_t;

	// Bias modulation setup
	typedef struct packed {
		cfg_word_t freq_cnt; // Clocks per half period, 4 or more
		cfg_word_t amp_h;    // DAC level, high half
		cfg_word_t amp_l;    // DAC level, low half
	} mod_cfg_t;

	// Demodulator setup
	typedef struct packed {
		cfg_word_t                       wait_cnt;   // Settle clocks per half, < freq_cnt
		logic signed [`FOG_DATA_W-1:0]   err_offset; // Added after polarity
		logic                            polarity;   // Negate high-minus-low
	} err_cfg_t;

	// Step generator setup
	typedef struct packed {
		logic                            fb_on;      // Closed loop when set
		logic [4:0]                      gain_sel;   // Arith shift of filtered error
		logic signed [`FOG_DATA_W-1:0]   const_step; // Open loop step
	} fb_cfg_t;

endpackage

//--- fog_data_pkg.sv
`include "fog_macros.svh"

package fog_data_pkg;

	// Two's complement ADC sample
	typedef logic signed [`FOG_ADC_W-1:0] adc_sample_t;

	// Errors, steps and the phase ramp all share this word
	typedef logic signed [`FOG_DATA_W-1:0] fog_word_t;

	// Word on the DAC bus, offset binary wrap is fine
	typedef logic [`FOG_DAC_W-1:0] dac_word_t;

	// One error per modulation period
	// stb high for a single clock, value held until next strobe
	typedef struct packed {
		logic      stb;   // Single-cycle valid
		fog_word_t value; // Raw or filtered error
	} err_stb_t;

	// FIR coefficient, Q15 style
	typedef logic signed [15:0] fir_coeff_t;

	// Low-pass set, symmetric
	// tap 0 multiplies the newest error
	localparam fir_coeff_t N8FC2 [`FOG_FIR_TAPS] = '{
		16'sd661,
		16'sd2126,
		16'sd5452,
		16'sd8144,
		16'sd8144,
		16'sd5452,
		16'sd2126,
		16'sd661
	};

endpackage

//--- fog_mod_demod.sv
`timescale 1ns/1ps

module fog_mod_demod (
	input  logic                     i_clock_adc,
	input  logic                     i_rst,
	input  fog_data_pkg::adc_sample_t i_adc,
	input  fog_cfg_pkg::mod_cfg_t    i_mod_cfg,
	input  fog_cfg_pkg::err_cfg_t    i_err_cfg,
	output logic                     o_mod_high,
	output fog_data_pkg::err_stb_t   o_err
);

	import fog_cfg_pkg::*;
	import fog_data_pkg::*;

	cfg_word_t cnt_q;      // Position inside current half
	logic      mod_high_q; // Current half, high first after reset
	fog_word_t sum_h_q;    // Gated sample sum, high half
	fog_word_t sum_l_q;    // Gated sample sum, low half
	err_stb_t  err_q;

	logic      last_cnt;
	logic      take;
	logic      period_end;
	fog_word_t adc_ext;
	fog_word_t sum_l_nxt;
	fog_word_t diff;
	fog_word_t err_nxt;

	assign last_cnt   = (cnt_q == i_mod_cfg.freq_cnt - 1'b1);
	assign take       = (cnt_q >= i_err_cfg.wait_cnt); // Past the settle window
	assign period_end = last_cnt & ~mod_high_q;         // Last clock of low half
	assign adc_ext    = fog_word_t'(i_adc);             // Sign extend

	// Low sum including the sample of this clock
	// the last low sample belongs in the error
	assign sum_l_nxt = take ? (sum_l_q + adc_ext) : sum_l_q;

	assign diff    = sum_h_q - sum_l_nxt;
	assign err_nxt = (i_err_cfg.polarity ? -diff : diff) + i_err_cfg.err_offset;

	// Half counter and phase flag
	always_ff @(posedge i_clock_adc) begin
		if (i_rst) begin
			cnt_q      <= '0;
			mod_high_q <= 1'b1;
		end else if (last_cnt) begin
			cnt_q      <= '0;
			mod_high_q <= ~mod_high_q; // Toggle on last count
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// Synchronous demodulation sums
	always_ff @(posedge i_clock_adc) begin
		if (i_rst) begin
			sum_h_q <= '0;
			sum_l_q <= '0;
		end else if (period_end) begin
			// New period starts from empty sums
			sum_h_q <= '0;
			sum_l_q <= '0;
		end else if (take) begin
			if (mod_high_q)
				sum_h_q <= sum_h_q + adc_ext;
			else
				sum_l_q <= sum_l_nxt;
		end
	end

	// Period error, strobed with first clock of next high half
	always_ff @(posedge i_clock_adc) begin
		if (i_rst) begin
			err_q.stb   <= 1'b0;
			err_q.value <= '0;
		end else begin
			err_q.stb <= period_end;
			if (period_end)
				err_q.value <= err_nxt; // Held until next period
		end
	end

	assign o_mod_high = mod_high_q; // ADC timing uses this too
	assign o_err      = err_q;

endmodule

//--- fog_err_fir.sv
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_err_fir (
	input  logic                   i_clock_adc,
	input  logic                   i_rst,
	input  fog_data_pkg::err_stb_t i_err,
	output fog_data_pkg::err_stb_t o_err
);

	import fog_data_pkg::*;

	fog_word_t taps_q   [`FOG_FIR_TAPS]; // Error history, tap 0 newest
	fog_word_t taps_nxt [`FOG_FIR_TAPS]; // History once current strobe is in
	err_stb_t  fir_q;

	logic signed [2*`FOG_DATA_W-1:0] mac;    // Wide enough for 8 products
	logic signed [2*`FOG_DATA_W-1:0] mac_sh;

	// Shifted view of the line
	always_comb begin
		taps_nxt[0] = i_err.value;
		for (int k = 1; k < `FOG_FIR_TAPS; k++)
			taps_nxt[k] = taps_q[k-1];
	end

	// Multiply-accumulate over N8FC2
	always_comb begin
		mac = '0;
		for (int k = 0; k < `FOG_FIR_TAPS; k++)
			mac = mac + (2*`FOG_DATA_W)'(taps_nxt[k]) * (2*`FOG_DATA_W)'(N8FC2[k]);
	end

	assign mac_sh = mac >>> `FOG_FIR_SHIFT; // Back to error scale

	// Delay line only moves on an error strobe
	always_ff @(posedge i_clock_adc) begin
		if (i_rst) begin
			for (int k = 0; k < `FOG_FIR_TAPS; k++)
				taps_q[k] <= '0; // Zero history
		end else if (i_err.stb) begin
			for (int k = 0; k < `FOG_FIR_TAPS; k++)
				taps_q[k] <= taps_nxt[k];
		end
	end

	// Result one clock after the raw strobe
	always_ff @(posedge i_clock_adc) begin
		if (i_rst) begin
			fir_q.stb   <= 1'b0;
			fir_q.value <= '0;
		end else begin
			fir_q.stb <= i_err.stb;
			if (i_err.stb)
				fir_q.value <= mac_sh[`FOG_DATA_W-1:0]; // Low word, top bits are sign
		end
	end

	assign o_err = fir_q;

endmodule

//--- fog_feedback.sv
`timescale 1ns/1ps

module fog_feedback (
	input  logic                    i_clock_adc,
	input  logic                    i_rst,
	input  fog_data_pkg::err_stb_t  i_err,
	input  fog_cfg_pkg::fb_cfg_t    i_fb_cfg,
	output fog_data_pkg::fog_word_t o_step
);

	import fog_data_pkg::*;

	fog_word_t step_q;   // Current ramp slope
	fog_word_t err_gain; // Filtered error after gain shift
	fog_word_t step_nxt;

	// Gain is a power of two, sign kept
	assign err_gain = i_err.value >>> i_fb_cfg.gain_sel;

	// Closed loop integrates, open loop just holds the fixed step
	assign step_nxt = i_fb_cfg.fb_on ? (step_q + err_gain) : i_fb_cfg.const_step;

	always_ff @(posedge i_clock_adc) begin
		if (i_rst)
			step_q <= '0;
		else if (i_err.stb)
			step_q <= step_nxt; // One update per period
	end

	assign o_step = step_q;

endmodule

//--- fog_ramp_dac.sv
`timescale 1ns/1ps

module fog_ramp_dac (
	input  logic                    i_clock_adc,
	input  logic                    i_rst,
	input  fog_data_pkg::fog_word_t i_step,
	input  logic                    i_mod_high,
	input  fog_cfg_pkg::mod_cfg_t   i_mod_cfg,
	output fog_data_pkg::dac_word_t o_dac
);

	import fog_data_pkg::*;

	fog_word_t ramp_q;  // Phase ramp, wraps mod 2^32
	dac_word_t dac_q;
	dac_word_t mod_lvl; // Bias level of this half
	dac_word_t dac_nxt;

	assign mod_lvl = i_mod_high ? dac_word_t'(i_mod_cfg.amp_h) : dac_word_t'(i_mod_cfg.amp_l);

	// Ramp low bits plus bias, wraps on the DAC width
	assign dac_nxt = dac_word_t'(ramp_q) + mod_lvl;

	// Integrator, step added every clock
	always_ff @(posedge i_clock_adc) begin
		if (i_rst)
			ramp_q <= '0;
		else
			ramp_q <= ramp_q + i_step;
	end

	// DAC word lags ramp and phase by one clock
	always_ff @(posedge i_clock_adc) begin
		if (i_rst)
			dac_q <= '0;
		else
			dac_q <= dac_nxt;
	end

	assign o_dac = dac_q;

endmodule

//--- fog_loop_top.sv
`timescale 1ns/1ps

module fog_loop_top (
	input  logic                      i_clock_adc,
	input  logic                      i_rst,
	input  fog_data_pkg::adc_sample_t i_adc,
	input  fog_cfg_pkg::mod_cfg_t     i_mod_cfg,
	input  fog_cfg_pkg::err_cfg_t     i_err_cfg,
	input  fog_cfg_pkg::fb_cfg_t      i_fb_cfg,
	output logic                      o_mod_high,
	output fog_data_pkg::err_stb_t    o_err_raw,
	output fog_data_pkg::err_stb_t    o_err_fir,
	output fog_data_pkg::fog_word_t   o_step,
	output fog_data_pkg::dac_word_t   o_dac
);

	// Bias modulation and period error
	fog_mod_demod fog_mod_demod_i (
		.i_clock_adc (i_clock_adc),
		.i_rst       (i_rst),
		.i_adc       (i_adc),
		.i_mod_cfg   (i_mod_cfg),
		.i_err_cfg   (i_err_cfg),
		.o_mod_high  (o_mod_high), // Phase flag, also to ramp
		.o_err       (o_err_raw)
	);

	// Error smoothing, one clock behind raw
	fog_err_fir fog_err_fir_i (
		.i_clock_adc (i_clock_adc),
		.i_rst       (i_rst),
		.i_err       (o_err_raw),
		.o_err       (o_err_fir)
	);

	// Feedback step, one clock behind filtered error
	fog_feedback fog_feedback_i (
		.i_clock_adc (i_clock_adc),
		.i_rst       (i_rst),
		.i_err       (o_err_fir),
		.i_fb_cfg    (i_fb_cfg),
		.o_step      (o_step)
	);

	// Ramp integrator and DAC word
	fog_ramp_dac fog_ramp_dac_i (
		.i_clock_adc (i_clock_adc),
		.i_rst       (i_rst),
		.i_step      (o_step),
		.i_mod_high  (o_mod_high),
		.i_mod_cfg   (i_mod_cfg), // Bias levels per half
		.o_dac       (o_dac)
	);

endmodule

//--- tb_fog_loop.sv
`timescale 1ns/1ps
`include "fog_macros.svh"

module tb_fog_loop;

	import fog_cfg_pkg::*;
	import fog_data_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_PER    = 64; // Level table depth beyond any test length
	localparam int F_MAX      = 16; // Largest freq_cnt used below
	localparam int NUM_TESTS  = 8;
	localparam int TOTAL_PER  = 4 + 5 + 5 + 5 + 12 + 12 + 6 + 8;
	// One spare period per test for reset and the first strobe plus slack
	localparam int WD_CYCLES  = (TOTAL_PER + NUM_TESTS) * 2 * F_MAX + NUM_TESTS * 10 + 200;

	logic        i_clock_adc;
	logic        i_rst;
	adc_sample_t i_adc;
	mod_cfg_t    i_mod_cfg;
	err_cfg_t    i_err_cfg;
	fb_cfg_t     i_fb_cfg;
	logic        o_mod_high;
	err_stb_t    o_err_raw;
	err_stb_t    o_err_fir;
	fog_word_t   o_step;
	dac_word_t   o_dac;

	integer seed = 56;
	int     errors;
	int     checks;
	int     tests_run;
	int     tests_failed;
	string  cur_test;

	int hi_lvl [MAX_PER]; // ADC level per period in the high half
	int lo_lvl [MAX_PER]; // ADC level per period in the low half
	int per_idx;
	bit seen_low;

	fog_word_t exp_raw  [$]; // Model output with one entry per period
	fog_word_t exp_fir  [$];
	fog_word_t exp_step [$];
	fog_word_t step_exp;     // Step expected between updates

	bit        active;   // Comparer enabled
	int        cyc;      // Clocks since reset release
	int        raw_cnt;
	int        step_cnt;
	bit        raw_d;    // Raw strobe seen last clock
	bit        fir_d;
	dac_word_t d_1;      // DAC word one clock back
	fog_word_t s_1;
	fog_word_t s_2;      // Step two clocks back
	logic      m_1;
	logic      m_2;

	fog_loop_top fog_loop_top_i (
		.i_clock_adc (i_clock_adc),
		.i_rst       (i_rst),
		.i_adc       (i_adc),
		.i_mod_cfg   (i_mod_cfg),
		.i_err_cfg   (i_err_cfg),
		.i_fb_cfg    (i_fb_cfg),
		.o_mod_high  (o_mod_high),
		.o_err_raw   (o_err_raw),
		.o_err_fir   (o_err_fir),
		.o_step      (o_step),
		.o_dac       (o_dac)
	);

	always #(CLK_PERIOD / 2) i_clock_adc = ~i_clock_adc;

	// Error for constant levels over the gated part of each half
	function automatic int period_err(int hi, int lo, int cnt, bit pol, int off);
		int diff;
		diff = cnt * (hi - lo);
		if (pol)
			diff = -diff; // Flipped loop sense
		return diff + off;
	endfunction

	// N8FC2 over the history with tap 0 newest
	function automatic int fir_out(int hist [`FOG_FIR_TAPS]);
		longint acc = 0;
		for (int k = 0; k < `FOG_FIR_TAPS; k++)
			acc += longint'(hist[k]) * longint'(N8FC2[k]);
		return int'(acc >>> `FOG_FIR_SHIFT);
	endfunction

	function automatic int step_next(int prev, int fir, bit on, int gain, int cst);
		if (on)
			return prev + (fir >>> gain); // Integrate gain-shifted error
		return cst;
	endfunction

	// Next DAC word from the ramp slope and the level change
	function automatic dac_word_t dac_next(dac_word_t prev, int step, dac_word_t lvl_now,
		dac_word_t lvl_old);
		dac_word_t step_lo;
		step_lo = step[`FOG_DAC_W-1:0];
		return prev + step_lo + lvl_now - lvl_old;
	endfunction

	function automatic mod_cfg_t make_mod(int freq, int amp_h, int amp_l);
		mod_cfg_t m;
		m.freq_cnt = freq;
		m.amp_h    = amp_h;
		m.amp_l    = amp_l;
		return m;
	endfunction

	function automatic err_cfg_t make_err(int wait_c, int off, bit pol);
		err_cfg_t e;
		e.wait_cnt   = wait_c;
		e.err_offset = off;
		e.polarity   = pol;
		return e;
	endfunction

	function automatic fb_cfg_t make_fb(bit on, int gain, int cst);
		fb_cfg_t f;
		f.fb_on      = on;
		f.gain_sel   = gain[4:0];
		f.const_step = cst;
		return f;
	endfunction

	task automatic check_val(string name, logic signed [63:0] exp_v, logic signed [63:0] act_v);
		checks++;
		if (act_v !== exp_v) begin
			errors++;
			$display("MISMATCH %s %s at %0t: expected %0d, actual %0d",
				cur_test, name, $time, exp_v, act_v);
		end
	endtask

	task automatic report_fail(string what);
		errors++;
		$display("ERROR %s at %0t: %s", cur_test, $time, what);
	endtask

	task automatic fill_const_levels(int hi, int lo);
		for (int p = 0; p < MAX_PER; p++) begin
			hi_lvl[p] = hi;
			lo_lvl[p] = lo;
		end
	endtask

	task automatic fill_random_levels();
		for (int p = 0; p < MAX_PER; p++) begin
			hi_lvl[p] = $random(seed) % 8192; // Stays inside 14 bits
			lo_lvl[p] = $random(seed) % 8192;
		end
	endtask

	// ADC level picked from the half shown at this falling edge
	always @(negedge i_clock_adc) begin
		if (i_rst) begin
			per_idx  = 0;
			seen_low = 1'b0;
		end else if (o_mod_high && seen_low) begin
			if (per_idx < MAX_PER - 1)
				per_idx++; // Period starts with high half
			seen_low = 1'b0;
		end else if (!o_mod_high) begin
			seen_low = 1'b1;
		end
		i_adc <= adc_sample_t'(o_mod_high ? hi_lvl[per_idx] : lo_lvl[per_idx]);
	end

	// Comparer reads the values settled since the last falling edge
	always @(posedge i_clock_adc) begin
		dac_word_t lvl_1;
		dac_word_t lvl_2;
		if (i_rst) begin
			cyc      = 0;
			raw_d    = 1'b0;
			fir_d    = 1'b0;
			step_exp = '0;
		end else begin
			cyc++;
			if (active) begin
				if (o_err_raw.stb) begin
					if (raw_cnt == 0)
						check_val("first raw strobe clock", 2 * i_mod_cfg.freq_cnt, cyc - 1);
					if (exp_raw.size() == 0)
						report_fail("raw error strobe with no period left to expect");
					else
						check_val("raw error", exp_raw.pop_front(), o_err_raw.value);
					raw_cnt++;
				end
				if (o_err_fir.stb !== raw_d)
					report_fail("filtered strobe not exactly one clock after raw strobe");
				if (o_err_fir.stb) begin
					if (exp_fir.size() == 0)
						report_fail("filtered strobe with no error left to expect");
					else
						check_val("fir error", exp_fir.pop_front(), o_err_fir.value);
				end
				if (fir_d && exp_step.size() != 0) begin
					step_exp = exp_step.pop_front(); // Update one clock after fir
					check_val("step update", step_exp, o_step);
					step_cnt++;
				end else begin
					check_val("step hold", step_exp, o_step);
				end
				if (cyc >= 3) begin
					lvl_1 = m_1 ? i_mod_cfg.amp_h[`FOG_DAC_W-1:0]
						: i_mod_cfg.amp_l[`FOG_DAC_W-1:0];
					lvl_2 = m_2 ? i_mod_cfg.amp_h[`FOG_DAC_W-1:0]
						: i_mod_cfg.amp_l[`FOG_DAC_W-1:0];
					check_val("dac word", dac_next(d_1, s_2, lvl_1, lvl_2), o_dac);
				end
			end
			raw_d = o_err_raw.stb;
			fir_d = o_err_fir.stb;
			s_2   = s_1;
			s_1   = o_step;
			m_2   = m_1;
			m_1   = o_mod_high;
			d_1   = o_dac;
		end
	end

	// Reset, expected sequences, then run until every step update is seen
	task automatic run_test(string name, mod_cfg_t m, err_cfg_t e, fb_cfg_t f, int nper);
		int hist [`FOG_FIR_TAPS];
		int cnt;
		int raw;
		int fir;
		int stp;
		int err_start;
		int chk_start;
		@(negedge i_clock_adc);
		active    = 1'b0;
		cur_test  = name;
		err_start = errors;
		chk_start = checks;
		i_rst     <= 1'b1;
		i_mod_cfg <= m;
		i_err_cfg <= e;
		i_fb_cfg  <= f;
		exp_raw.delete();
		exp_fir.delete();
		exp_step.delete();
		cnt = int'(m.freq_cnt) - int'(e.wait_cnt); // Samples per half
		stp = 0;
		for (int k = 0; k < `FOG_FIR_TAPS; k++)
			hist[k] = 0;
		for (int p = 0; p < nper; p++) begin
			raw = period_err(hi_lvl[p], lo_lvl[p], cnt, e.polarity, e.err_offset);
			for (int k = `FOG_FIR_TAPS - 1; k > 0; k--)
				hist[k] = hist[k-1];
			hist[0] = raw;
			fir = fir_out(hist);
			stp = step_next(stp, fir, f.fb_on, f.gain_sel, f.const_step);
			exp_raw.push_back(raw);
			exp_fir.push_back(fir);
			exp_step.push_back(stp);
		end
		repeat (3) @(negedge i_clock_adc);
		check_val("reset mod_high", 1, o_mod_high);
		check_val("reset err_raw", 0, o_err_raw);
		check_val("reset err_fir", 0, o_err_fir);
		check_val("reset step", 0, o_step);
		check_val("reset dac", 0, o_dac);
		raw_cnt  = 0;
		step_cnt = 0;
		active   = 1'b1;
		i_rst    <= 1'b0;
		wait (step_cnt == nper);
		@(negedge i_clock_adc);
		tests_run++;
		if (errors != err_start)
			tests_failed++;
		$display("test %s: %s, %0d checks, %0d errors", name,
			(errors == err_start) ? "ok" : "failed", checks - chk_start, errors - err_start);
	endtask

	initial begin
		fog_word_t cst;
		int        gain;
		i_clock_adc  = 1'b0;
		i_rst        = 1'b1;
		i_adc        = '0;
		i_mod_cfg    = make_mod(8, 0, 0);
		i_err_cfg    = make_err(0, 0, 1'b0);
		i_fb_cfg     = make_fb(1'b0, 0, 0);
		active       = 1'b0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "init";

		fill_const_levels(100, -50);
		run_test("reset_state", make_mod(10, 'h4000, 'hc000), make_err(0, 0, 1'b0),
			make_fb(1'b0, 0, 0), 4);
		fill_const_levels(1500, -2200);
		run_test("demod_plain", make_mod(8, 0, 0), make_err(0, 0, 1'b0),
			make_fb(1'b0, 0, 0), 5);
		run_test("demod_polarity", make_mod(8, 0, 0), make_err(0, 0, 1'b1),
			make_fb(1'b0, 0, 0), 5);
		fill_const_levels(-3000, 4100);
		run_test("demod_wait_offset", make_mod(16, 0, 0), make_err(5, -777, 1'b1),
			make_fb(1'b0, 0, 0), 5);
		fill_random_levels();
		run_test("fir_random", make_mod(12, 0, 0), make_err(2, 0, 1'b0),
			make_fb(1'b0, 0, 0), 12);
		fill_random_levels();
		gain = $unsigned($random(seed)) % 10;
		run_test("closed_loop", make_mod(12, 'h0800, 'hf800), make_err(1, 0, 1'b0),
			make_fb(1'b1, gain, 0), 12);
		fill_random_levels();
		cst = $random(seed);
		run_test("open_loop", make_mod(10, 0, 0), make_err(0, 0, 1'b0),
			make_fb(1'b0, 0, cst), 6);
		fill_const_levels(0, 0);
		run_test("ramp_dac", make_mod(9, 'h1f40, 'he0c0), make_err(0, 0, 1'b0),
			make_fb(1'b0, 0, 'h0001_2345), 8);
		active = 1'b0;

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Bound on the whole run with every test period at the largest freq_cnt
	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("ERROR %s: watchdog expired before the tests finished", cur_test);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
fog_cfg_pkg.sv
fog_data_pkg.sv
fog_mod_demod.sv
fog_err_fir.sv
fog_feedback.sv
fog_ramp_dac.sv
fog_loop_top.sv
tb_fog_loop.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FOG loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_fog_loop -o sim_fog_loop
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_fog_loop)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Pass only on the exact result line
if echo "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
